//--- Bender.yml
package:
  name: display_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/display_pkg.sv
      - common/canvas_pkg.sv
      - source/display_timings.sv
      - canvas/canvas_ram.sv
      - canvas/canvas_arbiter.sv
      - canvas/canvas_reader.sv
      - source/palette_colour.sv
      - source/display_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/display_top_tb.sv

//--- canvas/canvas_arbiter.sv
/* framebuffer port arbiter
   display reads win, a colliding host write waits one cycle */
`timescale 1ns/1ns

module canvas_arbiter import canvas_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     rd_req,
    input  fb_addr_t rd_addr,
    input  logic     fb_wr,
    input  fb_addr_t fb_addr,
    input  fb_word_t fb_data,
    output logic     en,
    output logic     we,
    output fb_addr_t addr,
    output fb_word_t wdata
);

    logic     pend_valid;  // host write held back by a read
    fb_addr_t pend_addr;
    fb_word_t pend_data;

    // port select: reader, then pending write, then fresh host write
    always_comb begin
        en    = 1'b0;
        we    = 1'b0;
        addr  = rd_addr;
        wdata = fb_data;
        if (rd_req) begin
            en = 1'b1;  // read only
        end else if (pend_valid) begin
            en    = 1'b1;
            we    = 1'b1;
            addr  = pend_addr;
            wdata = pend_data;
        end else if (fb_wr) begin
            en   = 1'b1;
            we   = 1'b1;
            addr = fb_addr;  // straight through
        end
    end

    // pending write survives only while a read keeps the port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= rd_req && (fb_wr || pend_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (fb_wr && rd_req) begin
            pend_addr <= fb_addr;  // capture the losing write
            pend_data <= fb_data;
        end
    end

    // host writes must not pile up behind a pending one
    a_no_wr_on_pend: assert property (@(posedge clk) disable iff (!arst_n)
        pend_valid |-> !fb_wr);

    // reader leaves a free slot after every fetch
    a_rd_spaced: assert property (@(posedge clk) disable iff (!arst_n)
        rd_req |=> !rd_req);

endmodule

//--- canvas/canvas_ram.sv
/* framebuffer word memory
   single port, registered read, no reset like a block RAM */
`timescale 1ns/1ns

`include "display_cfg.svh"

module canvas_ram import canvas_pkg::*; (
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  fb_addr_t addr,
    input  fb_word_t wdata,
    output fb_word_t rd_data
);

    fb_word_t mem [`FB_DEPTH];  // word array

    // one access per cycle, write or read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rd_data <= mem[addr];  // valid the cycle after the read
            end
        end
    end

endmodule

//--- canvas/canvas_reader.sv
/* canvas reader
   window test, integer scaling, word fetch with one-word hold and pixel unpack */
`timescale 1ns/1ns

`include "display_cfg.svh"

module canvas_reader import display_pkg::*, canvas_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  coord_t   sx,
    input  coord_t   sy,
    input  logic     de,
    output logic     rd_req,
    output fb_addr_t rd_addr,
    input  fb_word_t rd_data,
    output pix_idx_t pix,
    output logic     in_window
);

    localparam int PIX_PER_WORD = `FB_WORD_BITS / `CANV_BPP;
    localparam int SLOT_BITS    = $clog2(PIX_PER_WORD);

    localparam coord_t WIN_X0 = coord_t'(`WIN_STARTX);
    localparam coord_t WIN_Y0 = coord_t'(`WIN_STARTY);
    localparam coord_t WIN_X1 = coord_t'(`WIN_STARTX + `CANV_WIDTH * `CANV_SCALE);
    localparam coord_t WIN_Y1 = coord_t'(`WIN_STARTY + `CANV_HEIGHT * `CANV_SCALE);

    logic                 in_win_s0;  // stage 0 window hit
    coord_t               cx, cy;     // canvas coordinates
    coord_t               lin;        // linear pixel number
    fb_addr_t             word_addr;
    logic [SLOT_BITS-1:0] slot_s0;
    fb_addr_t             last_addr;  // word tracker
    logic                 last_valid;
    logic                 issued_s1;  // stage 1 sees fresh rd_data
    logic                 win_s1;
    logic [SLOT_BITS-1:0] slot_s1;
    fb_word_t             held_word;
    fb_word_t             cur_word;

    assign in_win_s0 = de && (sx >= WIN_X0) && (sx < WIN_X1) && (sy >= WIN_Y0) && (sy < WIN_Y1);
    assign cx        = (sx - WIN_X0) / coord_t'(`CANV_SCALE);  // wraps outside, gated anyway
    assign cy        = (sy - WIN_Y0) / coord_t'(`CANV_SCALE);
    assign lin       = cy * coord_t'(`CANV_WIDTH) + cx;
    assign word_addr = fb_addr_t'(lin / coord_t'(PIX_PER_WORD));
    assign slot_s0   = lin[SLOT_BITS-1:0];  // eight pixels per word

    // fetch only on a word change
    assign rd_req  = in_win_s0 && (!last_valid || (word_addr != last_addr));
    assign rd_addr = word_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_valid <= 1'b0;
            last_addr  <= '0;
            issued_s1  <= 1'b0;
            win_s1     <= 1'b0;
            in_window  <= 1'b0;
        end else begin
            if (sx == '0) begin
                last_valid <= 1'b0;  // new line, forget the held word
            end else if (rd_req) begin
                last_valid <= 1'b1;
                last_addr  <= word_addr;
            end
            issued_s1 <= rd_req;
            win_s1    <= in_win_s0;
            in_window <= win_s1;
        end
    end

    // rd_data is only valid the cycle right after the request
    assign cur_word = issued_s1 ? rd_data : held_word;

    always_ff @(posedge clk) begin
        slot_s1 <= slot_s0;
        if (issued_s1) begin
            held_word <= rd_data;
        end
        pix <= cur_word[slot_s1 * `CANV_BPP +: `CANV_BPP];  // unpack the slot
    end

endmodule

//--- common/canvas_pkg.sv
/* framebuffer side types
   word addresses, packed pixel words and palette indices */
package canvas_pkg;

`include "display_cfg.svh"

    // word address into the framebuffer
    typedef logic [$clog2(`FB_DEPTH)-1:0] fb_addr_t;

    // pixel 0 sits in the lowest bits
    typedef logic [`FB_WORD_BITS-1:0] fb_word_t;

    typedef logic [`CANV_BPP-1:0] pix_idx_t;  // palette index

endpackage

//--- common/display_cfg.svh
/* display engine configuration
   tiny display format, canvas window placement and background colour */
`ifndef DISPLAY_CFG_SVH
`define DISPLAY_CFG_SVH

// horizontal timing in pixels
`define H_ACTIVE      16
`define H_FRONT       1
`define H_SYNC        2
`define H_BACK        1

// vertical timing in lines
`define V_ACTIVE      8
`define V_FRONT       1
`define V_SYNC        1
`define V_BACK        1

`define CANV_WIDTH    6         // canvas width in pixels
`define CANV_HEIGHT   3         // canvas height in lines
`define CANV_BPP      2         // bits per pixel
`define CANV_SCALE    2         // integer scaling factor
`define WIN_STARTX    2         // window origin on screen
`define WIN_STARTY    1
`define FB_WORD_BITS  16        // framebuffer word width
`define FB_DEPTH      4         // framebuffer words
`define BG_COLR       15'h0886  // background colour, RGB555

`endif

//--- common/display_pkg.sv
/* display side types
   screen coordinates, RGB555 colour and board channel width */
package display_pkg;

    // screen position, wide enough for the full horizontal and vertical totals
    typedef logic [7:0] coord_t;

    // packed {r, g, b}, 5 bits each, red on top
    typedef logic [14:0] colr555_t;

    typedef logic [7:0] chan8_t;  // one board colour channel

    // field positions inside colr555_t
    localparam int R_LSB = 10;
    localparam int G_LSB = 5;
    localparam int B_LSB = 0;
    localparam int CHAN5_BITS = 5;

endpackage

//--- source/display_timings.sv
/* display timing generator
   free-running counters giving position, syncs, data enable and frame strobe */
`timescale 1ns/1ns

`include "display_cfg.svh"

module display_timings import display_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   de,
    output logic   hsync,
    output logic   vsync,
    output logic   frame
);

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT    = coord_t'(`H_ACTIVE);
    localparam coord_t V_ACT    = coord_t'(`V_ACTIVE);
    localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
    localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
    localparam coord_t VS_END   = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic line_end;  // last pixel of the line

    assign line_end = (sx == H_LAST);

    // reset parks the counters at the very last blanking position,
    // so every decoded output is low and the first frame starts one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sx <= H_LAST;
            sy <= V_LAST;
        end else if (line_end) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    assign de    = (sx < H_ACT) && (sy < V_ACT);
    assign hsync = (sx >= HS_START) && (sx < HS_END);  // active high
    assign vsync = (sy >= VS_START) && (sy < VS_END);
    assign frame = (sx == '0) && (sy == '0);           // first pixel of frame

    // counter never escapes the horizontal total
    a_sx_range: assert property (@(posedge clk) disable iff (!arst_n)
        sx < coord_t'(H_TOTAL));

endmodule

//--- source/display_top.sv
/* indexed-colour display engine
   timing, canvas fetch through a shared framebuffer, palette and aligned syncs */
`timescale 1ns/1ns

module display_top import display_pkg::*, canvas_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     fb_wr,     // host framebuffer write
    input  fb_addr_t fb_addr,
    input  fb_word_t fb_data,
    input  logic     pal_wr,    // host palette write
    input  pix_idx_t pal_idx,
    input  colr555_t pal_colr,
    output chan8_t   r,
    output chan8_t   g,
    output chan8_t   b,
    output logic     de,
    output logic     hsync,
    output logic     vsync,
    output logic     frame
);

    localparam int SYNC_DLY = 3;  // reader 2 + colour stage 1

    coord_t   sx, sy;
    logic     t_de, t_hsync, t_vsync, t_frame;  // straight from the timing counters
    logic     rd_req;
    fb_addr_t rd_addr;
    fb_word_t rd_data;
    logic     ram_en, ram_we;
    fb_addr_t ram_addr;
    fb_word_t ram_wdata;
    pix_idx_t pix;
    logic     in_window;
    logic [SYNC_DLY-1:0] de_q, hsync_q, vsync_q, frame_q;

    display_timings u_timings (.clk, .arst_n, .sx, .sy, .de(t_de), .hsync(t_hsync),
        .vsync(t_vsync), .frame(t_frame));

    canvas_reader u_reader (.clk, .arst_n, .sx, .sy, .de(t_de), .rd_req, .rd_addr,
        .rd_data, .pix, .in_window);

    canvas_arbiter u_arbiter (.clk, .arst_n, .rd_req, .rd_addr, .fb_wr, .fb_addr, .fb_data,
        .en(ram_en), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata));

    canvas_ram u_ram (.clk, .en(ram_en), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
        .rd_data);

    palette_colour u_colour (.clk, .arst_n, .pal_wr, .pal_idx, .pal_colr, .pix, .in_window,
        .r, .g, .b);

    // match the colour pipeline latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_q    <= '0;
            hsync_q <= '0;
            vsync_q <= '0;
            frame_q <= '0;
        end else begin
            de_q    <= {de_q[SYNC_DLY-2:0], t_de};
            hsync_q <= {hsync_q[SYNC_DLY-2:0], t_hsync};
            vsync_q <= {vsync_q[SYNC_DLY-2:0], t_vsync};
            frame_q <= {frame_q[SYNC_DLY-2:0], t_frame};
        end
    end

    assign de    = de_q[SYNC_DLY-1];
    assign hsync = hsync_q[SYNC_DLY-1];
    assign vsync = vsync_q[SYNC_DLY-1];
    assign frame = frame_q[SYNC_DLY-1];

endmodule

//--- source/palette_colour.sv
/* palette and colour output stage
   four-entry palette, background outside the window, RGB555 to 8-bit channels */
`timescale 1ns/1ns

`include "display_cfg.svh"

module palette_colour import display_pkg::*, canvas_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     pal_wr,
    input  pix_idx_t pal_idx,
    input  colr555_t pal_colr,
    input  pix_idx_t pix,
    input  logic     in_window,
    output chan8_t   r,
    output chan8_t   g,
    output chan8_t   b
);

    localparam int PAL_SIZE = 2 ** `CANV_BPP;

    colr555_t pal [PAL_SIZE];  // palette registers
    colr555_t colr;            // selected colour

    // 5 bits to 8, top bits repeated underneath
    function automatic chan8_t widen(input logic [CHAN5_BITS-1:0] c);
        return {c, c[CHAN5_BITS-1 -: 3]};
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PAL_SIZE; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_wr) begin
            pal[pal_idx] <= pal_colr;  // visible from the next cycle
        end
    end

    assign colr = in_window ? pal[pix] : colr555_t'(`BG_COLR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            r <= widen(colr[R_LSB +: CHAN5_BITS]);
            g <= widen(colr[G_LSB +: CHAN5_BITS]);
            b <= widen(colr[B_LSB +: CHAN5_BITS]);
        end
    end

endmodule

//--- tests/display_top_tb.sv
/* display engine testbench
   table-driven host writes, picture and sync checked against a reference model */
`timescale 1ns/1ns

`include "display_cfg.svh"

module display_top_tb import display_pkg::*, canvas_pkg::*; ();

    localparam int H_TOTAL      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_LEN    = H_TOTAL * V_TOTAL;
    localparam int HS_START     = `H_ACTIVE + `H_FRONT;
    localparam int VS_START     = `V_ACTIVE + `V_FRONT;
    localparam int PIX_PER_WORD = `FB_WORD_BITS / `CANV_BPP;
    localparam int N_STEPS      = 16;
    localparam int LIMIT        = N_STEPS * FRAME_LEN * 2;  // cycle budget for the whole run
    localparam int K_PAL   = 0;  // step kinds
    localparam int K_FB    = 1;
    localparam int K_LIVE  = 2;  // framebuffer write at an offset into a scanned frame
    localparam int K_CHECK = 3;

    logic     clk, arst_n;
    logic     fb_wr, pal_wr;
    fb_addr_t fb_addr;
    fb_word_t fb_data;
    pix_idx_t pal_idx;
    colr555_t pal_colr;
    chan8_t   r, g, b;
    logic     de, hsync, vsync, frame;

    int       step_kind [N_STEPS];
    int       step_addr [N_STEPS];
    fb_word_t step_data [N_STEPS];
    int       step_dly  [N_STEPS];
    colr555_t model_pal [4];           // reference copies
    fb_word_t model_fb  [`FB_DEPTH];
    int       err_colr, err_flag, err_count;
    int       cycles, seed_ret;

    display_top uut (.clk, .arst_n, .fb_wr, .fb_addr, .fb_data, .pal_wr, .pal_idx, .pal_colr,
        .r, .g, .b, .de, .hsync, .vsync, .frame);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // widen a 5-bit channel to 8 bits by repeating its top three bits underneath
    function automatic chan8_t expand5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // colour the picture should show at screen position x, y
    function automatic colr555_t expect_colr(input int x, input int y);
        int       cx, cy, n;
        fb_word_t w;
        pix_idx_t idx;
        if (x < `WIN_STARTX || x >= `WIN_STARTX + `CANV_WIDTH * `CANV_SCALE ||
            y < `WIN_STARTY || y >= `WIN_STARTY + `CANV_HEIGHT * `CANV_SCALE) begin
            return colr555_t'(`BG_COLR);
        end
        cx  = (x - `WIN_STARTX) / `CANV_SCALE;
        cy  = (y - `WIN_STARTY) / `CANV_SCALE;
        n   = cy * `CANV_WIDTH + cx;          // linear canvas pixel
        w   = model_fb[n / PIX_PER_WORD];
        idx = w[(n % PIX_PER_WORD) * `CANV_BPP +: `CANV_BPP];
        return model_pal[idx];
    endfunction

    task automatic check_colr(input string name, input chan8_t got, input chan8_t exp);
        if (got !== exp) begin
            err_colr++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_flag++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_count++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_idle();
        check_flag("de", de, 1'b0);
        check_flag("hsync", hsync, 1'b0);
        check_flag("vsync", vsync, 1'b0);
        check_flag("frame", frame, 1'b0);
    endtask

    // always moves on to a frame pulse strictly after the current cycle
    task automatic wait_new_frame();
        @(negedge clk);
        while (frame !== 1'b1) @(negedge clk);
    endtask

    task automatic fb_write(input fb_addr_t a, input fb_word_t d);
        @(posedge clk);
        fb_wr   <= 1'b1;
        fb_addr <= a;
        fb_data <= d;
        model_fb[a] = d;
        @(posedge clk);
        fb_wr <= 1'b0;
        @(posedge clk);  // keeps host writes two cycles apart
    endtask

    task automatic pal_write(input pix_idx_t i, input colr555_t c);
        @(posedge clk);
        pal_wr   <= 1'b1;
        pal_idx  <= i;
        pal_colr <= c;
        model_pal[i] = c;
        @(posedge clk);
        pal_wr <= 1'b0;
    endtask

    // checks one whole frame from its pulse with syncs by cycle offset and colours by own x and y
    task automatic check_frame();
        int       x, y, n_de, hpos, line;
        colr555_t exp;
        wait_new_frame();
        x    = 0;
        y    = 0;
        n_de = 0;
        for (int cyc = 0; cyc < FRAME_LEN; cyc++) begin
            hpos = cyc % H_TOTAL;
            line = cyc / H_TOTAL;
            check_flag("frame", frame, cyc == 0);
            check_flag("de", de, hpos < `H_ACTIVE && line < `V_ACTIVE);
            check_flag("hsync", hsync, hpos >= HS_START && hpos < HS_START + `H_SYNC);
            check_flag("vsync", vsync, line >= VS_START && line < VS_START + `V_SYNC);
            if (frame) begin
                x = 0;  // model restarts on the frame pulse
                y = 0;
            end
            if (de) begin
                exp = expect_colr(x, y);
                check_colr("r", r, expand5(exp[R_LSB +: CHAN5_BITS]));
                check_colr("g", g, expand5(exp[G_LSB +: CHAN5_BITS]));
                check_colr("b", b, expand5(exp[B_LSB +: CHAN5_BITS]));
                n_de++;
                x++;
                if (x == `H_ACTIVE) begin
                    x = 0;
                    y++;
                end
            end
            @(negedge clk);
        end
        check_count("de pixels", n_de, `H_ACTIVE * `V_ACTIVE);
        check_count("lines", y, `V_ACTIVE);
    endtask

    task automatic add_step(input int i, input int kind, input int a, input fb_word_t d,
                            input int dly);
        step_kind[i] = kind;
        step_addr[i] = a;
        step_data[i] = d;
        step_dly[i]  = dly;
    endtask

    task automatic load_table();
        add_step(0, K_PAL, 0, 16'h7c00, 0);   // four distinct colours
        add_step(1, K_PAL, 1, 16'h03e0, 0);
        add_step(2, K_PAL, 2, 16'h001f, 0);
        add_step(3, K_PAL, 3, 16'h5ad6, 0);
        for (int i = 0; i < `FB_DEPTH; i++) begin
            add_step(4 + i, K_FB, i, fb_word_t'($urandom), 0);
        end
        add_step(8, K_CHECK, 0, '0, 0);
        add_step(9, K_PAL, 2, 16'h2d4b, 0);   // rewrite between frames
        add_step(10, K_CHECK, 0, '0, 0);
        // first write misses the reader and the rest hit its fetches on window rows 1, 3 and 5
        add_step(11, K_LIVE, 0, fb_word_t'($urandom), 30);
        add_step(12, K_LIVE, 0, fb_word_t'($urandom), 19);
        add_step(13, K_LIVE, 1, fb_word_t'($urandom), 63);
        add_step(14, K_LIVE, 2, fb_word_t'($urandom), 107);
        add_step(15, K_CHECK, 0, '0, 0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        arst_n   = 1'b0;
        fb_wr    = 1'b0;
        fb_addr  = '0;
        fb_data  = '0;
        pal_wr   = 1'b0;
        pal_idx  = '0;
        pal_colr = '0;
        err_colr  = 0;
        err_flag  = 0;
        err_count = 0;
        seed_ret  = $urandom(48);
        for (int i = 0; i < 4; i++) model_pal[i] = '0;  // palette resets to 0
        for (int i = 0; i < `FB_DEPTH; i++) model_fb[i] = '0;
        load_table();
        repeat (4) begin
            @(negedge clk);
            check_idle();
            check_colr("r", r, 8'h00);
            check_colr("g", g, 8'h00);
            check_colr("b", b, 8'h00);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) begin  // pipeline still empty after release
            @(negedge clk);
            check_idle();
        end
        for (int i = 0; i < N_STEPS; i++) begin
            case (step_kind[i])
                K_PAL: pal_write(pix_idx_t'(step_addr[i]), colr555_t'(step_data[i]));
                K_FB:  fb_write(fb_addr_t'(step_addr[i]), step_data[i]);
                K_LIVE: begin
                    wait_new_frame();
                    repeat (step_dly[i] - 1) @(posedge clk);
                    fb_write(fb_addr_t'(step_addr[i]), step_data[i]);
                end
                default: check_frame();
            endcase
        end
        $display("errors: colour %0d, flag %0d, count %0d", err_colr, err_flag, err_count);
        if (err_colr + err_flag + err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/display_pkg.sv
common/canvas_pkg.sv
source/display_timings.sv
canvas/canvas_ram.sv
canvas/canvas_arbiter.sv
canvas/canvas_reader.sv
source/palette_colour.sv
source/display_top.sv
tests/display_top_tb.sv
